//--- Bender.yml
package:
  name: gateway_link_hub

sources:
  - logic/gw_pkg.sv
  - logic/tag_trace_replay.sv
  - logic/flit_dispatcher.sv
  - logic/link_channel.sv
  - logic/link_collector.sv
  - logic/gateway_link_hub.sv
  - target: test
    files:
      - dv/gateway_link_hub_properties.sv
      - dv/tb_gateway_link_hub.sv

//--- dv/gateway_link_hub_properties.sv
`timescale 1ns/10ps

module gateway_link_hub_properties
  (
    input logic                          clk_i,
    input logic                          rst_n_i,
    input logic                          in_ready_o,
    input logic                          out_valid_o,
    input gw_pkg::flit_u                 out_flit_o,
    input logic                          out_ready_i,
    input logic                          cfg_done_o,
    input logic [gw_pkg::DROP_CNT_W-1:0] drop_count_o
  );

  int unsigned fail_count = 0;

  ////////////////////////////////////////////////////////////
  // Stream handshakes

  // Stalled output holds its flit
  a_out_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_flit_o))
  else
  begin
    fail_count++;
    $error("out_flit_o changed or out_valid_o dropped while stalled");
  end

  ////////////////////////////////////////////////////////////
  // Configuration and counters

  a_no_ready_before_cfg : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !cfg_done_o |-> !in_ready_o)
  else
  begin
    fail_count++;
    $error("in_ready_o high before cfg_done_o");
  end

  a_cfg_done_sticky : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_done_o |=> cfg_done_o)
  else
  begin
    fail_count++;
    $error("cfg_done_o fell after the trace ended");
  end

  a_drop_monotonic : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    1'b1 |=> drop_count_o >= $past(drop_count_o))
  else
  begin
    fail_count++;
    $error("drop_count_o went backwards");
  end

  a_reset_quiet : assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !out_valid_o && !cfg_done_o && (drop_count_o == '0))
  else
  begin
    fail_count++;
    $error("outputs not idle right after reset");
  end

endmodule

//--- dv/tb_gateway_link_hub.sv
`timescale 1ns/10ps

module tb_gateway_link_hub;

  import gw_pkg::*;

  localparam int          SEED         = 32'h22b;
  localparam int          CLK_PERIOD   = 8;
  localparam int          NUM_PKTS     = 60;
  localparam int          MAX_PKT_LEN  = 16;
  localparam int          STALL_FACTOR = 40;
  localparam int          TIMEOUT_NS   = NUM_PKTS * MAX_PKT_LEN * STALL_FACTOR * CLK_PERIOD;
  localparam int          OFF_LINK     = 3;
  // Credits programmed by logic/tag_trace.mem
  localparam int          INIT_CREDIT [NUM_LINKS] = '{3, 2, 4, 0};

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  in_valid_i;
  flit_u                 in_flit_i;
  logic                  in_ready_o;
  logic                  out_valid_o;
  flit_u                 out_flit_o;
  logic                  out_ready_i;
  logic [NUM_LINKS-1:0]  token_i;
  logic                  cfg_done_o;
  logic [DROP_CNT_W-1:0] drop_count_o;

  // Expected flits per link, header first
  logic [FLIT_W-1:0]     exp_q [NUM_LINKS][$];
  int                    tok_cnt [NUM_LINKS];
  int                    out_cnt [NUM_LINKS];
  int                    err_count  = 0;
  int                    flits_seen = 0;
  int                    pending    = 0;
  int                    drop_sent  = 0;
  int                    out_remain = 0;
  int                    cur_link   = 0;
  logic                  stim_done;

  gateway_link_hub u_gateway_link_hub
    (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .in_valid_i   (in_valid_i),
      .in_flit_i    (in_flit_i),
      .in_ready_o   (in_ready_o),
      .out_valid_o  (out_valid_o),
      .out_flit_o   (out_flit_o),
      .out_ready_i  (out_ready_i),
      .token_i      (token_i),
      .cfg_done_o   (cfg_done_o),
      .drop_count_o (drop_count_o)
    );

  bind gateway_link_hub gateway_link_hub_properties u_hub_props (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard

  task automatic check_out_flit(input int link, input logic [FLIT_W-1:0] got);
    logic [FLIT_W-1:0] exp;
    logic              known;
    known = (link != OFF_LINK) && (exp_q[link].size() != 0);
    assert (known)
    else
    begin
      err_count++;
      $display("Flit %h reached the output for link %0d but was never sent there", got, link);
    end
    if (known)
    begin
      exp = exp_q[link].pop_front();
      pending--;
      out_cnt[link]++;
      assert (got == exp)
      else
      begin
        err_count++;
        $display("[ERROR] out_flit_o (link %0d): got %h expected %h", link, got, exp);
      end
      assert (out_cnt[link] <= INIT_CREDIT[link] + tok_cnt[link])
      else
      begin
        err_count++;
        $display("Link %0d sent %0d flits with only %0d credits granted", link,
                 out_cnt[link], INIT_CREDIT[link] + tok_cnt[link]);
      end
    end
  endtask

  always @(posedge clk_i)
  begin : scoreboard
    flit_u got;
    if (rst_n_i && !cfg_done_o)
    begin
      assert (!in_ready_o)
      else
      begin
        err_count++;
        $display("[ERROR] in_ready_o: got %h expected %h before cfg_done_o", in_ready_o, 1'b0);
      end
    end
    if (rst_n_i && out_valid_o && out_ready_i)
    begin
      got = out_flit_o;
      flits_seen++;
      if (out_remain == 0)
      begin
        cur_link   = got.hdr.dest;
        out_remain = got.hdr.len;
      end
      else
        out_remain--;
      check_out_flit(cur_link, got.data);
    end
    // Tokens counted after the check, a token this edge cannot cover a flit already out
    for (int i = 0; i < NUM_LINKS; i++)
      if (rst_n_i && token_i[i])
        tok_cnt[i]++;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus

  task automatic send_flit(input logic [FLIT_W-1:0] word);
    in_valid_i     = 1'b1;
    in_flit_i.data = word;
    @(posedge clk_i);
    while (!in_ready_o)
      @(posedge clk_i);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    if (($urandom % 4) == 0)
      repeat ($urandom % 3) @(negedge clk_i);
  endtask

  task automatic send_packet(input int dest, input int len, input int tag);
    flit_u             hdr;
    logic [FLIT_W-1:0] words [$];
    hdr.hdr.dest = LINK_IDX_W'(dest);
    hdr.hdr.len  = LEN_W'(len);
    hdr.hdr.tag  = SEQ_TAG_W'(tag);
    words.push_back(hdr.data);
    for (int i = 0; i < len; i++)
      words.push_back(FLIT_W'($urandom));
    if (dest == OFF_LINK)
      drop_sent++;
    else
      foreach (words[i])
      begin
        exp_q[dest].push_back(words[i]);
        pending++;
      end
    foreach (words[i])
      send_flit(words[i]);
  endtask

  // Far end of the links: output stalls and returned tokens
  task automatic drive_link_side();
    while (!stim_done)
    begin
      @(negedge clk_i);
      out_ready_i = (($urandom % 4) != 0);
      for (int i = 0; i < NUM_LINKS; i++)
        token_i[i] = (($urandom % 4) == 0);
    end
    out_ready_i = 1'b1;
    token_i     = '0;
  endtask

  task automatic print_summary();
    $display("Summary: %0d packets, %0d flits checked, %0d dropped, %0d errors, %0d assert fails",
             NUM_PKTS, flits_seen, drop_sent, err_count, u_gateway_link_hub.u_hub_props.fail_count);
  endtask

  initial
  begin : main
    int dest;
    int len;
    void'($urandom(SEED));
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_flit_i   = '0;
    out_ready_i = 1'b0;
    token_i     = '0;
    stim_done   = 1'b0;
    for (int i = 0; i < NUM_LINKS; i++)
    begin
      tok_cnt[i] = 0;
      out_cnt[i] = 0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    assert (!out_valid_o && !in_ready_o && !cfg_done_o && drop_count_o == '0)
    else
    begin
      err_count++;
      $display("[ERROR] after reset: out_valid_o %h in_ready_o %h cfg_done_o %h drop_count_o %h",
               out_valid_o, in_ready_o, cfg_done_o, drop_count_o);
    end

    len = 0;
    while (!cfg_done_o && len <= TRACE_DEPTH + 1)
    begin
      @(negedge clk_i);
      len++;
    end
    assert (cfg_done_o && len <= TRACE_DEPTH + 1)
    else
    begin
      err_count++;
      $display("cfg_done_o did not rise within %0d cycles after reset", TRACE_DEPTH + 1);
    end

    fork
      drive_link_side();
      begin
        for (int p = 0; p < NUM_PKTS; p++)
        begin
          dest = $urandom % NUM_LINKS;
          len  = $urandom % MAX_PKT_LEN;
          send_packet(dest, len, p);
        end
        wait (pending == 0);
        repeat (10) @(negedge clk_i);
        stim_done = 1'b1;
      end
    join

    assert (drop_count_o == DROP_CNT_W'(drop_sent))
    else
    begin
      err_count++;
      $display("[ERROR] drop_count_o: got %h expected %h", drop_count_o, DROP_CNT_W'(drop_sent));
    end
    assert (out_remain == 0)
    else
    begin
      err_count++;
      $display("Output stream stopped inside a packet, %0d data flits missing", out_remain);
    end

    print_summary();
    if (err_count == 0 && u_gateway_link_hub.u_hub_props.fail_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS + 20 * CLK_PERIOD);
    $display("Timeout: run still busy after %0d ns with %0d flits outstanding",
             TIMEOUT_NS + 20 * CLK_PERIOD, pending);
    print_summary();
    $display("test failed");
    $finish;
  end

endmodule

//--- flist.f
logic/gw_pkg.sv
logic/tag_trace_replay.sv
logic/flit_dispatcher.sv
logic/link_channel.sv
logic/link_collector.sv
logic/gateway_link_hub.sv
dv/gateway_link_hub_properties.sv
dv/tb_gateway_link_hub.sv

//--- logic/flit_dispatcher.sv
`timescale 1ns/10ps

module flit_dispatcher
  (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             en_i,
    input  logic                             in_valid_i,
    input  gw_pkg::flit_u                    in_flit_i,
    output logic                             in_ready_o,
    input  logic [gw_pkg::NUM_LINKS-1:0]     link_en_i,
    output logic [gw_pkg::NUM_LINKS-1:0]     push_o,
    output gw_pkg::link_flit_s               push_flit_o,
    input  logic [gw_pkg::NUM_LINKS-1:0]     push_ready_i,
    output logic [gw_pkg::DROP_CNT_W-1:0]    drop_count_o
  );

  import gw_pkg::*;

  // Data flits still owed by the current packet, zero means header next
  logic [LEN_W-1:0]      remain_q;
  logic [LINK_IDX_W-1:0] dest_q;
  logic                  drop_q;
  logic [DROP_CNT_W-1:0] drop_cnt_q;

  logic                  is_hdr;
  logic [LINK_IDX_W-1:0] dest_cur;
  logic                  drop_cur;
  logic                  last_cur;
  logic                  accept;

  assign is_hdr   = (remain_q == '0);
  assign dest_cur = is_hdr ? in_flit_i.hdr.dest : dest_q;
  assign drop_cur = is_hdr ? !link_en_i[in_flit_i.hdr.dest] : drop_q;
  assign last_cur = is_hdr ? (in_flit_i.hdr.len == '0) : (remain_q == LEN_W'(1));

  // Dropped packets are swallowed without waiting on any FIFO
  assign in_ready_o = en_i && (drop_cur || push_ready_i[dest_cur]);
  assign accept     = in_valid_i && in_ready_o;

  always_comb
  begin
    push_o = '0;
    if (accept && !drop_cur)
      push_o[dest_cur] = 1'b1;
  end

  assign push_flit_o.flit = in_flit_i;
  assign push_flit_o.last = last_cur;

  ////////////////////////////////////////////////////////////
  // Packet tracking

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      remain_q   <= '0;
      dest_q     <= '0;
      drop_q     <= 1'b0;
      drop_cnt_q <= '0;
    end
    else if (accept)
    begin
      if (is_hdr)
      begin
        remain_q <= in_flit_i.hdr.len;
        dest_q   <= in_flit_i.hdr.dest;
        drop_q   <= drop_cur;
        if (drop_cur)
          drop_cnt_q <= drop_cnt_q + 1'b1;
      end
      else
      begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  assign drop_count_o = drop_cnt_q;

endmodule

//--- logic/gateway_link_hub.sv
`timescale 1ns/10ps

module gateway_link_hub
  (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          in_valid_i,
    input  gw_pkg::flit_u                 in_flit_i,
    output logic                          in_ready_o,
    output logic                          out_valid_o,
    output gw_pkg::flit_u                 out_flit_o,
    input  logic                          out_ready_i,
    input  logic [gw_pkg::NUM_LINKS-1:0]  token_i,
    output logic                          cfg_done_o,
    output logic [gw_pkg::DROP_CNT_W-1:0] drop_count_o
  );

  import gw_pkg::*;

  link_cfg_s              link_cfg;
  logic [NUM_LINKS-1:0]   link_en;
  logic [NUM_LINKS-1:0]   push;
  link_flit_s             push_flit;
  logic [NUM_LINKS-1:0]   push_ready;
  logic [NUM_LINKS-1:0]   ch_valid;
  link_flit_s             ch_flit [NUM_LINKS];
  logic [NUM_LINKS-1:0]   ch_pop;

  ////////////////////////////////////////////////////////////
  // Configuration trace

  tag_trace_replay u_tag_trace_replay
    (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .cfg_o   (link_cfg),
      .done_o  (cfg_done_o)
    );

  // Traffic held off until the trace is done
  flit_dispatcher u_flit_dispatcher
    (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .en_i         (cfg_done_o),
      .in_valid_i   (in_valid_i),
      .in_flit_i    (in_flit_i),
      .in_ready_o   (in_ready_o),
      .link_en_i    (link_en),
      .push_o       (push),
      .push_flit_o  (push_flit),
      .push_ready_i (push_ready),
      .drop_count_o (drop_count_o)
    );

  ////////////////////////////////////////////////////////////
  // Link channels

  for (genvar g = 0; g < NUM_LINKS; g++)
  begin : g_link
    link_channel u_link_channel
      (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .link_idx_i   (LINK_IDX_W'(g)),
        .cfg_i        (link_cfg),
        .token_i      (token_i[g]),
        .push_i       (push[g]),
        .push_flit_i  (push_flit),
        .push_ready_o (push_ready[g]),
        .enabled_o    (link_en[g]),
        .valid_o      (ch_valid[g]),
        .flit_o       (ch_flit[g]),
        .pop_i        (ch_pop[g])
      );
  end

  link_collector u_link_collector
    (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .valid_i     (ch_valid),
      .flit_i      (ch_flit),
      .pop_o       (ch_pop),
      .out_valid_o (out_valid_o),
      .out_flit_o  (out_flit_o),
      .out_ready_i (out_ready_i)
    );

endmodule

//--- logic/gw_pkg.sv
package gw_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes

  localparam int NUM_LINKS   = 4;
  localparam int LINK_IDX_W  = 2;
  localparam int FLIT_W      = 16;
  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_PTR_W  = 3;
  localparam int FIFO_CNT_W  = 4;
  localparam int CREDIT_W    = 4;
  localparam int LEN_W       = 4;
  localparam int SEQ_TAG_W   = 10;
  localparam int DROP_CNT_W  = 16;
  localparam int TRACE_DEPTH = 8;
  localparam int TRACE_ADDR_W = 3;
  localparam int TRACE_W     = 12;

  localparam string TRACE_FILE = "logic/tag_trace.mem";

  ////////////////////////////////////////////////////////////
  // Flit views

  // Header view, first flit of every packet
  typedef struct packed {
    logic [LINK_IDX_W-1:0] dest;
    logic [LEN_W-1:0]      len;
    logic [SEQ_TAG_W-1:0]  tag;
  } flit_hdr_s;

  typedef union packed {
    flit_hdr_s         hdr;
    logic [FLIT_W-1:0] data;
  } flit_u;

  typedef struct packed {
    flit_u flit;
    logic  last;
  } link_flit_s;

  ////////////////////////////////////////////////////////////
  // Configuration trace

  typedef enum logic [1:0] {
    TRACE_NOP = 2'b00,
    TRACE_CFG = 2'b01,
    TRACE_END = 2'b10
  } trace_op_e;

  typedef struct packed {
    trace_op_e             op;
    logic [LINK_IDX_W-1:0] link;
    logic                  en;
    logic [CREDIT_W-1:0]   credit;
    logic [2:0]            spare;
  } trace_entry_s;

  typedef struct packed {
    logic                  we;
    logic [LINK_IDX_W-1:0] link;
    logic                  en;
    logic [CREDIT_W-1:0]   credit;
  } link_cfg_s;

endpackage

//--- logic/link_channel.sv
`timescale 1ns/10ps

module link_channel
  (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [gw_pkg::LINK_IDX_W-1:0] link_idx_i,
    input  gw_pkg::link_cfg_s             cfg_i,
    input  logic                          token_i,
    input  logic                          push_i,
    input  gw_pkg::link_flit_s            push_flit_i,
    output logic                          push_ready_o,
    output logic                          enabled_o,
    output logic                          valid_o,
    output gw_pkg::link_flit_s            flit_o,
    input  logic                          pop_i
  );

  import gw_pkg::*;

  link_flit_s            mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic [CREDIT_W-1:0]   credit_q;
  logic                  en_q;

  logic                  do_push;
  logic                  do_pop;
  logic                  cfg_hit;

  assign push_ready_o = (count_q != FIFO_CNT_W'(FIFO_DEPTH));
  assign valid_o      = (count_q != '0) && (credit_q != '0);
  assign flit_o       = mem[rd_ptr_q];
  assign enabled_o    = en_q;

  assign do_push = push_i && push_ready_o;
  assign do_pop  = pop_i && valid_o;
  assign cfg_hit = cfg_i.we && (cfg_i.link == link_idx_i);

  ////////////////////////////////////////////////////////////
  // Flit FIFO

  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem[wr_ptr_q] <= push_flit_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop)
        count_q <= count_q + 1'b1;
      else if (!do_push && do_pop)
        count_q <= count_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Token credit and enable

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      credit_q <= '0;
      en_q     <= 1'b0;
    end
    else if (cfg_hit)
    begin
      credit_q <= cfg_i.credit;
      en_q     <= cfg_i.en;
    end
    else if (token_i && !do_pop)
    begin
      // Saturate, the far end never owes more than this
      if (credit_q != '1)
        credit_q <= credit_q + 1'b1;
    end
    else if (!token_i && do_pop)
    begin
      credit_q <= credit_q - 1'b1;
    end
  end

endmodule

//--- logic/link_collector.sv
`timescale 1ns/10ps

module link_collector
  (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [gw_pkg::NUM_LINKS-1:0] valid_i,
    input  gw_pkg::link_flit_s           flit_i [gw_pkg::NUM_LINKS],
    output logic [gw_pkg::NUM_LINKS-1:0] pop_o,
    output logic                         out_valid_o,
    output gw_pkg::flit_u                out_flit_o,
    input  logic                         out_ready_i
  );

  import gw_pkg::*;

  // Link holding the grant, or the last one served when unlocked
  logic [LINK_IDX_W-1:0] grant_q;
  logic                  locked_q;
  logic                  out_valid_q;
  flit_u                 out_flit_q;

  logic [LINK_IDX_W-1:0] pick;
  logic                  pick_found;
  logic [LINK_IDX_W-1:0] sel;
  logic                  sel_valid;
  logic                  can_load;
  logic                  take;

  ////////////////////////////////////////////////////////////
  // Round robin pick, starting after the last grant

  always_comb
  begin : rr_pick
    logic [LINK_IDX_W-1:0] cand;
    pick       = grant_q;
    pick_found = 1'b0;
    for (int i = 1; i <= NUM_LINKS; i++)
    begin
      cand = grant_q + LINK_IDX_W'(i);
      if (!pick_found && valid_i[cand])
      begin
        pick       = cand;
        pick_found = 1'b1;
      end
    end
  end

  // Stay on the granted link until its last flit, even when it runs dry
  assign sel       = locked_q ? grant_q : pick;
  assign sel_valid = locked_q ? valid_i[grant_q] : pick_found;
  assign can_load  = !out_valid_q || out_ready_i;
  assign take      = can_load && sel_valid;

  always_comb
  begin
    pop_o = '0;
    if (take)
      pop_o[sel] = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Output register

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      grant_q     <= LINK_IDX_W'(NUM_LINKS - 1);
      locked_q    <= 1'b0;
      out_valid_q <= 1'b0;
    end
    else if (take)
    begin
      grant_q     <= sel;
      locked_q    <= !flit_i[sel].last;
      out_valid_q <= 1'b1;
    end
    else if (out_ready_i)
    begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
      out_flit_q <= flit_i[sel].flit;
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

endmodule

//--- logic/tag_trace.mem
// One 12-bit entry per line: op[11:10] link[9:8] en[7] credit[6:3] spare[2:0]
// op 1 is CFG, 0 is NOP, 2 is END
498
590
000
6A0
700
800
000
000

//--- logic/tag_trace_replay.sv
`timescale 1ns/10ps

module tag_trace_replay
  (
    input  logic              clk_i,
    input  logic              rst_n_i,
    output gw_pkg::link_cfg_s cfg_o,
    output logic              done_o
  );

  import gw_pkg::*;

  logic [TRACE_W-1:0]      rom [TRACE_DEPTH];
  logic [TRACE_ADDR_W-1:0] addr_q;
  trace_entry_s            entry;
  link_cfg_s               cfg_q;
  logic                    done_q;
  logic                    last_entry;

  initial
  begin
    $readmemh(TRACE_FILE, rom);
  end

  // One entry per cycle, straight out of the ROM
  assign entry = rom[addr_q];

  // Running off the end counts as END
  assign last_entry = (entry.op == TRACE_END) ||
                      (addr_q == TRACE_ADDR_W'(TRACE_DEPTH - 1));

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      addr_q <= '0;
      done_q <= 1'b0;
    end
    else if (!done_q)
    begin
      if (last_entry)
        done_q <= 1'b1;
      else
        addr_q <= addr_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Config write, one cycle per CFG entry

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cfg_q <= '0;
    end
    else
    begin
      cfg_q.we     <= !done_q && (entry.op == TRACE_CFG);
      cfg_q.link   <= entry.link;
      cfg_q.en     <= entry.en;
      cfg_q.credit <= entry.credit;
    end
  end

  assign cfg_o  = cfg_q;
  assign done_o = done_q;

endmodule
